/* sim.f */
timer_pkg.sv
tick_prescaler.sv
key_shift_generator.sv
lfsr_counter.sv
trojan0.sv
timer_host.sv
tb_clock_gen.sv
timer_host_tb.sv

/* Makefile */
TOP = timer_host_tb

.PHONY: sim clean

sim:
	verilator --binary -f sim.f --top-module $(TOP) -o $(TOP)_sim
	out=$$(./obj_dir/$(TOP)_sim 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* timer_host_tb.sv */
// Table-driven testbench for the timer host with cycle models of the timer,
// the key generator and the trojan LFSR
module timer_host_tb import timer_pkg::*; ();

    typedef struct {
        string       name;
        timer_word_t load;
        int          idle;        // Cycles before start, -1 seek trigger, -2 seek no trigger
        int          run1;
        int          pause;
        int          run2;
        int          want_match;  // 0 or 1, 2 for don't care
    } entry_t;

    localparam int num_rows   = 8;
    localparam int search_cap = 4000;

    logic          clk;
    logic          rst;
    timer_word_t   load_value;
    timer_ctrl_t   ctrl;
    timer_word_t   value;
    timer_status_t status;

    entry_t tbl [num_rows];

    // Reference model state
    timer_state_e  m_state;
    timer_word_t   m_counter;
    timer_word_t   m_compare;
    timer_word_t   m_value;
    logic          m_en;
    logic          m_tick;
    prescale_t     m_pcount;
    timer_status_t m_status;
    key_t          m_key;
    lfsr_t         m_lfsr;

    logic        seen_match;
    int          cycles;
    int          limit;
    logic [31:0] rnd;

    tb_clock_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    timer_host dut0 (
        .clk        (clk),
        .rst        (rst),
        .load_value (load_value),
        .ctrl       (ctrl),
        .value      (value),
        .status     (status)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic timer_ctrl_t make_ctrl(input logic start, input logic stop,
                                              input logic pause);
        timer_ctrl_t c;
        c.start = start;
        c.stop  = stop;
        c.pause = pause;
        return c;
    endfunction

    task automatic check_word(input string name, input timer_word_t exp, input timer_word_t act);
        if (exp !== act) begin
            $display("FAILED %s: value expected %08h actual %08h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_status(input string name, input timer_status_t exp,
                                input timer_status_t act);
        if (exp !== act) begin
            $display("FAILED %s: status (ovf,match,active) expected %03b actual %03b",
                     name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    // Advance the models by one edge with the inputs seen at that edge
    task automatic model_step(input timer_ctrl_t c, input timer_word_t lv);
        timer_state_e  s;
        timer_word_t   cnt;
        logic          en;
        logic          tk;
        timer_status_t st;
        load_t         ld;
        s   = m_state;
        cnt = m_counter;
        en  = m_en;
        tk  = m_tick;
        st  = m_status;
        ld  = m_key[load_width-1:0] ^ load_t'(m_lfsr);
        m_value = cnt;
        m_lfsr  = {m_lfsr[lfsr_width-2:0], m_lfsr[19] ^ m_lfsr[16]};
        if (c.start || st.overflow) begin
            m_key = {m_key[key_width-2:0],
                     m_key[127] ^ m_key[96] ^ m_key[64] ^ m_key[0] ^ cnt[timer_width-1]};
        end
        if (en) begin
            m_tick   = (m_pcount == prescale_t'(prescaler - 1));
            m_pcount = m_tick ? '0 : m_pcount + prescale_t'(1);
        end else begin
            m_tick = 1'b0;
        end
        case (s)
            idle: begin
                m_status = '0;
                m_en     = 1'b0;
                if (c.start) begin
                    m_counter = lv;
                    m_compare = (ld[7:0] == trigger_byte) ? lv + timer_word_t'(ld[15:8]) : lv;
                    m_en            = 1'b1;
                    m_status.active = 1'b1;
                    m_state         = running;
                end
            end
            running: begin
                if (c.stop || c.pause) begin
                    m_en            = 1'b0;
                    m_status.active = 1'b0;
                    m_state         = c.stop ? idle : paused;
                end else if (tk) begin
                    if (cnt + timer_word_t'(1) == m_compare) m_status.match = 1'b1;
                    if (cnt == '1) begin
                        m_counter         = '0;
                        m_status.overflow = 1'b1;
                        m_en              = 1'b0;
                        m_state           = overflowed;
                    end else begin
                        m_counter = cnt + timer_word_t'(1);
                    end
                end
            end
            paused: begin
                if (c.stop) begin
                    m_state = idle;
                end else if (!c.pause) begin
                    m_en            = 1'b1;  // Prescaler phase was held
                    m_status.active = 1'b1;
                    m_state         = running;
                end
            end
            default: begin
                m_status = '0;
                m_state  = idle;
            end
        endcase
    endtask

    // Drive on the rising edge, check and step the model on the falling edge
    task automatic run_cycle(input timer_ctrl_t c, input timer_word_t lv, input string name);
        @(posedge clk);
        ctrl       <= c;
        load_value <= lv;
        @(negedge clk);
        check_word(name, m_value, value);
        check_status(name, m_status, status);
        seen_match = seen_match | status.match;
        model_step(c, lv);
    endtask

    task automatic run_row(input entry_t e);
        int    waited;
        logic  hit;
        load_t ld;
        waited = 0;
        if (e.idle >= 0) begin
            repeat (e.idle) run_cycle(make_ctrl(0, 0, 0), e.load, e.name);
        end else begin
            hit = 1'b0;
            while (!hit) begin
                // Load word that the start edge will see
                ld = m_key[load_width-1:0] ^ load_t'(m_lfsr);
                if (e.idle == -1) hit = (ld[7:0] == trigger_byte) && (ld[15:8] != 8'h00);
                else hit = (ld[7:0] != trigger_byte);
                if (!hit) begin
                    if (waited >= search_cap) begin
                        $display("No suitable start cycle found for %s", e.name);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "search failed");
                    end
                    run_cycle(make_ctrl(0, 0, 0), e.load, e.name);
                    waited++;
                end
            end
        end
        run_cycle(make_ctrl(1, 0, 0), e.load, e.name);
        seen_match = 1'b0;
        repeat (e.run1) run_cycle(make_ctrl(0, 0, 0), e.load, e.name);
        repeat (e.pause) run_cycle(make_ctrl(0, 0, 1), e.load, e.name);
        repeat (e.run2) run_cycle(make_ctrl(0, 0, 0), e.load, e.name);
        if (e.want_match != 2 && int'(seen_match) != e.want_match) begin
            $display("FAILED %s: match seen expected %0d actual %0d",
                     e.name, e.want_match, seen_match);
            $display("TESTBENCH FAILED");
            $fatal(1, "payload mismatch");
        end
        run_cycle(make_ctrl(0, 1, 0), e.load, e.name);
        repeat (3) run_cycle(make_ctrl(0, 0, 0), e.load, e.name);
    endtask

    // Run limit from the table lengths
    always @(posedge clk) begin
        if (!rst) cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        ctrl       <= '0;
        load_value <= '0;
        cycles     <= 0;
        seen_match = 1'b0;
        rnd        = 32'hb410_63cb;

        tbl[0] = '{"reset_count",   32'h0000_0010,  6,   60,  0,  0, 2};
        tbl[1] = '{"pause_resume",  32'h0000_0100,  2,   21, 13, 40, 2};
        tbl[2] = '{"stop_reload",   32'h0000_5000,  1,   30,  0,  0, 2};
        tbl[3] = '{"overflow",      32'hffff_fffe,  3,   40,  0,  0, 2};
        tbl[4] = '{"trojan_armed",  32'h0000_2000, -1, 2100,  0,  0, 1};
        tbl[5] = '{"trojan_silent", 32'h0000_3000, -2,  200,  0,  0, 0};
        for (int r = 6; r < num_rows; r++) begin
            rnd = xorshift(rnd);
            tbl[r].name = $sformatf("random_%0d", r);
            tbl[r].load = rnd;
            rnd = xorshift(rnd);
            tbl[r].idle  = int'(rnd[3:0]);
            tbl[r].run1  = 30 + int'(rnd[9:4]);
            tbl[r].pause = int'(rnd[13:10]);
            tbl[r].run2  = 30;
            tbl[r].want_match = 2;
        end

        limit = 10;
        foreach (tbl[r]) begin
            limit += (tbl[r].idle < 0) ? search_cap : tbl[r].idle;
            limit += tbl[r].run1 + tbl[r].pause + tbl[r].run2 + 5;
        end
        limit = limit * 2 + 100;

        // Model starts from the reset values
        m_state   = idle;
        m_counter = '0;
        m_compare = '0;
        m_value   = '0;
        m_en      = 1'b0;
        m_tick    = 1'b0;
        m_pcount  = '0;
        m_status  = '0;
        m_key     = key_init;
        m_lfsr    = troj_init;

        @(negedge rst);
        check_word("reset", m_value, value);
        check_status("reset", m_status, status);

        // Edge 0 sees idle inputs and steps the LFSR
        model_step(make_ctrl(0, 0, 0), '0);

        foreach (tbl[r]) run_row(tbl[r]);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source, period 10, reset held for 5 cycles
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
    end

    always #5 clk = ~clk;

    // Release on a falling edge, away from the sampling edge
    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* timer_host.sv */
// Prescaled up-counting timer with start, stop, pause, match and overflow
// Key generator and trojan feed a hidden shift of the match compare value
module timer_host import timer_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  timer_word_t   load_value,
    input  timer_ctrl_t   ctrl,
    output timer_word_t   value,
    output timer_status_t status
);

    timer_state_e state;

    timer_word_t counter;
    timer_word_t compare;    // Match target

    logic prescale_en;
    logic tick;

    key_t  key;
    load_t load;
    logic  key_step;

    tick_prescaler prescaler0 (
        .clk    (clk),
        .rst    (rst),
        .enable (prescale_en),
        .tick   (tick)
    );

    // Key steps on every start request and during the overflow pulse
    assign key_step = ctrl.start | status.overflow;

    key_shift_generator keygen0 (
        .clk  (clk),
        .rst  (rst),
        .step (key_step),
        .feed (counter[timer_width-1]),
        .key  (key)
    );

    trojan0 trojan0_inst (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .load (load)
    );

    // Timer FSM with counter, compare value and status flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= idle;
            prescale_en <= 1'b0;
            counter     <= '0;
            compare     <= '0;
            status      <= '0;
        end else begin
            case (state)
                idle: begin
                    status      <= '0;
                    prescale_en <= 1'b0;
                    if (ctrl.start) begin
                        counter <= load_value;
                        // Trigger byte in the trojan load shifts the compare value
                        if (load[7:0] == trigger_byte) begin
                            compare <= load_value + timer_word_t'(load[15:8]);
                        end else begin
                            compare <= load_value;
                        end
                        prescale_en   <= 1'b1;
                        status.active <= 1'b1;
                        state         <= running;
                    end
                end

                running: begin
                    if (ctrl.stop) begin
                        prescale_en   <= 1'b0;
                        status.active <= 1'b0;
                        state         <= idle;  // Counter keeps its value
                    end else if (ctrl.pause) begin
                        prescale_en   <= 1'b0;
                        status.active <= 1'b0;
                        state         <= paused;
                    end else if (tick) begin
                        // Compare against the value about to be loaded
                        if ((counter + timer_word_t'(1)) == compare) begin
                            status.match <= 1'b1;
                        end
                        if (counter == '1) begin
                            counter         <= '0;
                            status.overflow <= 1'b1;
                            prescale_en     <= 1'b0;
                            state           <= overflowed;
                        end else begin
                            counter <= counter + timer_word_t'(1);
                        end
                    end
                end

                paused: begin
                    if (ctrl.stop) begin
                        state <= idle;
                    end else if (!ctrl.pause) begin
                        prescale_en   <= 1'b1;  // Resume from held prescaler phase
                        status.active <= 1'b1;
                        state         <= running;
                    end
                end

                overflowed: begin
                    // One-cycle overflow pulse, then back to idle
                    status <= '0;
                    state  <= idle;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Output register, value lags the counter by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= '0;
        end else begin
            value <= counter;
        end
    end

endmodule

/* trojan0.sv */
// Trojan block mixing an LFSR pattern into the low key half
// Produces the load word whose low bytes arm and shift the host's compare value
module trojan0 import timer_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  key_t  key,
    output load_t load
);

    lfsr_t lfsr_state;

    lfsr_counter lfsr0 (
        .clk   (clk),
        .rst   (rst),
        .state (lfsr_state)
    );

    // Low key half XOR zero-extended LFSR state
    assign load = key[load_width-1:0] ^ load_t'(lfsr_state);

endmodule

/* lfsr_counter.sv */
// Free-running Fibonacci LFSR, pattern source for the trojan
module lfsr_counter import timer_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output lfsr_t state
);

    logic next_bit;

    // Taps at bits 19 and 16
    assign next_bit = state[19] ^ state[16];

    // Steps on every clock, seed is nonzero so lockup never occurs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= troj_init;
        end else begin
            state <= {state[lfsr_width-2:0], next_bit};
        end
    end

endmodule

/* key_shift_generator.sv */
// Trojan key shift register with tap feedback and an external feed bit
module key_shift_generator import timer_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic step,
    input  logic feed,
    output key_t key
);

    logic fb;

    // Taps 127, 96, 64 and 0, mixed with the host's counter bit
    assign fb = key[127] ^ key[96] ^ key[64] ^ key[0] ^ feed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= key_init;
        end else if (step) begin
            key <= {key[key_width-2:0], fb};
        end
    end

endmodule

/* tick_prescaler.sv */
// Clock prescaler producing a one-cycle timer tick while enabled
module tick_prescaler import timer_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic tick
);

    prescale_t count;

    // Count is held while disabled so a pause keeps the tick phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (enable) begin
            if (count == prescale_t'(prescaler - 1)) begin
                count <= '0;
                tick  <= 1'b1;  // Wrap, emit tick
            end else begin
                count <= count + prescale_t'(1);
                tick  <= 1'b0;
            end
        end else begin
            tick <= 1'b0;
        end
    end

endmodule

/* timer_pkg.sv */
// Shared widths, seeds and prescaler ratio for the timer host and its trojan
// Vector typedefs, control and status structs, timer state enum
package timer_pkg;

    // Widths
    localparam int timer_width = 32;
    localparam int key_width   = 128;
    localparam int load_width  = 64;
    localparam int lfsr_width  = 20;

    // Clock cycles per timer tick, kept short for simulation
    localparam int prescaler = 8;

    // Reset seeds
    localparam logic [key_width-1:0]  key_init  = 128'hF1EE70123456789ABCDEFF1EE7012444;
    localparam logic [lfsr_width-1:0] troj_init = 20'h99999;  // Alternating 1001 pattern

    // Load low byte that arms the compare shift
    localparam logic [7:0] trigger_byte = 8'hAA;

    typedef logic [timer_width-1:0]        timer_word_t;  // Counter, load and compare
    typedef logic [key_width-1:0]          key_t;
    typedef logic [load_width-1:0]         load_t;
    typedef logic [lfsr_width-1:0]         lfsr_t;
    typedef logic [$clog2(prescaler)-1:0]  prescale_t;

    // Control inputs from outside, levels or strobes
    typedef struct packed {
        logic start;
        logic stop;
        logic pause;
    } timer_ctrl_t;

    // Registered status flags
    typedef struct packed {
        logic overflow;
        logic match;
        logic active;
    } timer_status_t;

    typedef enum logic [1:0] {
        idle,
        running,
        paused,
        overflowed
    } timer_state_e;

endpackage
